// ==== platform_cfg_pkg.sv ====
//--------------------------------------------------------------------
// Platform controller configuration
// Synchronizer depth, system reset stretch length and the divide
// ratios of the peripheral clock-enable pulses
//--------------------------------------------------------------------
package platform_cfg_pkg;

  //------------------------------------------------------------------
  // Reset handling
  //------------------------------------------------------------------

  // Flops in each synchronizer chain
  localparam int unsigned SYNC_STAGES = 2;

  // Extra cycles of system reset after the last request drops
  localparam int unsigned RST_STRETCH = 8;

  //------------------------------------------------------------------
  // Peripheral clock enables
  //------------------------------------------------------------------

  // Pulse periods in MASTER_CLK cycles
  localparam int unsigned TIMER_DIV = 4;
  localparam int unsigned UART_DIV  = 8;
  localparam int unsigned WDOG_DIV  = 16;

  // Shared counter width
  // WDOG_DIV is the largest value any counter has to hold
  localparam int unsigned CNT_W = $clog2(WDOG_DIV + 1);

endpackage

// ==== platform_types_pkg.sv ====
//--------------------------------------------------------------------
// Platform controller types
// Reset cause encoding and the deep-sleep handshake states
//--------------------------------------------------------------------
package platform_types_pkg;

  // Source of the last system reset
  typedef enum logic [1:0] {
    CAUSE_POR    = 2'd0,
    CAUSE_SOFT   = 2'd1,
    CAUSE_WDOG   = 2'd2,
    CAUSE_LOCKUP = 2'd3
  } reset_cause_t;

  // Deep-sleep sequence
  // RUN -> WIC enable requested -> sleep hold requested -> asleep
  typedef enum logic [1:0] {
    LP_RUN      = 2'd0,
    LP_WIC_REQ  = 2'd1,
    LP_HOLD_REQ = 2'd2,
    LP_ASLEEP   = 2'd3
  } lp_state_t;

endpackage

// ==== platform_status_if.sv ====
//--------------------------------------------------------------------
// Platform status bundle
// Reset and power status shared by the reset, low-power and
// clock-enable blocks
//--------------------------------------------------------------------
`timescale 1ns/1ns

interface platform_status_if;
  import platform_types_pkg::*;

  // System reset, active low, and what caused it
  logic         sys_rst_n;
  reset_cause_t reset_cause;

  // Core is held in deep sleep
  logic         asleep;
  // Debugger has powered up the debug domain
  logic         dbg_powered;

  modport rst_src (
    output sys_rst_n,
    output reset_cause
  );

  modport lp_src (
    output asleep,
    output dbg_powered,
    input  sys_rst_n
  );

  modport consumer (
    input sys_rst_n,
    input asleep,
    input dbg_powered
  );

endinterface

// ==== reset_sync.sv ====
//--------------------------------------------------------------------
// Synchronizer chain
// Clears asynchronously on rst_n and passes d to q after STAGES
// rising edges of MASTER_CLK
//--------------------------------------------------------------------
`timescale 1ns/1ns

module reset_sync #(
  parameter int unsigned STAGES = platform_cfg_pkg::SYNC_STAGES
) (
  input  logic MASTER_CLK,
  input  logic rst_n,
  input  logic d,
  output logic q
);

  logic [STAGES-1:0] chain_q;

  always_ff @(posedge MASTER_CLK or negedge rst_n) begin
    if (!rst_n) begin
      chain_q <= '0;
    end else begin
      chain_q[0] <= d;
      // Shift towards the last stage
      for (int i = 1; i < STAGES; i++) begin
        chain_q[i] <= chain_q[i-1];
      end
    end
  end

  assign q = chain_q[STAGES-1];

  //------------------------------------------------------------------
  // Checks
  //------------------------------------------------------------------

  // Output must never show a released value during reset
  a_q_low_in_reset : assert property (
    @(posedge MASTER_CLK) !rst_n |-> !q
  );

endmodule

// ==== sys_reset_ctrl.sv ====
//--------------------------------------------------------------------
// System reset controller
// Merges software, watchdog and lockup reset requests into one
// stretched system reset, records the cause of the last one and
// drives the debug port reset
//--------------------------------------------------------------------
`timescale 1ns/1ns

module sys_reset_ctrl (
  input  logic               MASTER_CLK,
  input  logic               por_n,
  input  logic               sysresetreq_s,
  input  logic               wdog_req_s,
  input  logic               lockup_s,
  input  logic               dbgrstreq_s,
  output logic               dap_reset_n,
  output logic               cpu_sysreset_n,
  platform_status_if.rst_src status
);
  import platform_cfg_pkg::*;
  import platform_types_pkg::*;

  logic             any_req;
  logic             sys_rst_n_q;
  logic [CNT_W-1:0] stretch_q;
  reset_cause_t     cause_d;
  reset_cause_t     cause_q;
  logic             dap_reset_n_q;

  assign any_req = sysresetreq_s | wdog_req_s | lockup_s;

  // Watchdog wins over lockup, lockup over software
  always_comb begin
    if (wdog_req_s) begin
      cause_d = CAUSE_WDOG;
    end else if (lockup_s) begin
      cause_d = CAUSE_LOCKUP;
    end else begin
      cause_d = CAUSE_SOFT;
    end
  end

  //------------------------------------------------------------------
  // Reset stretch
  //------------------------------------------------------------------

  // Counter reloads while any request is up, counts down afterwards
  always_ff @(posedge MASTER_CLK or negedge por_n) begin
    if (!por_n) begin
      sys_rst_n_q <= 1'b0;
      stretch_q   <= '0;
    end else if (any_req) begin
      sys_rst_n_q <= 1'b0;
      stretch_q   <= CNT_W'(RST_STRETCH);
    end else if (stretch_q != '0) begin
      stretch_q   <= stretch_q - 1'b1;
    end else begin
      sys_rst_n_q <= 1'b1;
    end
  end

  // Cause is captured only on the edge where reset goes low
  always_ff @(posedge MASTER_CLK or negedge por_n) begin
    if (!por_n) begin
      cause_q <= CAUSE_POR;
    end else if (any_req && sys_rst_n_q) begin
      cause_q <= cause_d;
    end
  end

  // Debug reset, second stage of the request synchronizer
  always_ff @(posedge MASTER_CLK or negedge por_n) begin
    if (!por_n) begin
      dap_reset_n_q <= 1'b0;
    end else begin
      dap_reset_n_q <= ~dbgrstreq_s;
    end
  end

  assign cpu_sysreset_n     = sys_rst_n_q;
  assign dap_reset_n        = dap_reset_n_q;
  assign status.sys_rst_n   = sys_rst_n_q;
  assign status.reset_cause = cause_q;

  //------------------------------------------------------------------
  // Checks
  //------------------------------------------------------------------

  a_low_while_stretching : assert property (
    @(posedge MASTER_CLK) disable iff (!por_n)
    (stretch_q != '0) |-> !sys_rst_n_q
  );

  a_cause_on_fall_only : assert property (
    @(posedge MASTER_CLK) disable iff (!por_n)
    $changed(cause_q) |-> $fell(sys_rst_n_q)
  );

endmodule

// ==== lowpower_ctrl.sv ====
//--------------------------------------------------------------------
// Low-power controller
// Deep-sleep handshake with the wake-up controller (WIC enable,
// then sleep hold) and the debugger power-up acknowledges
//--------------------------------------------------------------------
`timescale 1ns/1ns

module lowpower_ctrl (
  input  logic              MASTER_CLK,
  input  logic              por_n,
  input  logic              sleep,
  input  logic              sleepdeep,
  input  logic              pmu_wic_en_ack,
  input  logic              sleepholdackn,
  input  logic              pmu_wakeup,
  input  logic              dbgpwrupreq_s,
  input  logic              dbgsyspwrupreq_s,
  output logic              pmu_wic_en_req,
  output logic              sleepholdreqn,
  output logic              dbgpwrupack,
  output logic              dbgsyspwrupack,
  platform_status_if.lp_src status
);
  import platform_types_pkg::*;

  lp_state_t state_q;
  lp_state_t state_d;
  logic      pwrup_ack_q;
  logic      syspwrup_ack_q;

  //------------------------------------------------------------------
  // Sleep FSM
  //------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    // Wake-up or system reset abort the sequence from any state
    if (pmu_wakeup || !status.sys_rst_n) begin
      state_d = LP_RUN;
    end else begin
      unique case (state_q)
        LP_RUN: begin
          if (sleep && sleepdeep) begin
            state_d = LP_WIC_REQ;
          end
        end
        LP_WIC_REQ: begin
          if (pmu_wic_en_ack) begin
            state_d = LP_HOLD_REQ;
          end
        end
        LP_HOLD_REQ: begin
          if (!sleepholdackn) begin
            state_d = LP_ASLEEP;
          end
        end
        default: begin
          state_d = LP_ASLEEP;
        end
      endcase
    end
  end

  always_ff @(posedge MASTER_CLK or negedge por_n) begin
    if (!por_n) begin
      state_q <= LP_RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // WIC enable stays up for the whole sequence
  assign pmu_wic_en_req = (state_q != LP_RUN);
  assign sleepholdreqn  = !((state_q == LP_HOLD_REQ) || (state_q == LP_ASLEEP));
  assign status.asleep  = (state_q == LP_ASLEEP);

  //------------------------------------------------------------------
  // Debugger power acknowledges
  //------------------------------------------------------------------

  always_ff @(posedge MASTER_CLK or negedge por_n) begin
    if (!por_n) begin
      pwrup_ack_q    <= 1'b0;
      syspwrup_ack_q <= 1'b0;
    end else begin
      pwrup_ack_q    <= dbgpwrupreq_s;
      syspwrup_ack_q <= dbgsyspwrupreq_s;
    end
  end

  assign dbgpwrupack        = pwrup_ack_q;
  assign dbgsyspwrupack     = syspwrup_ack_q;
  assign status.dbg_powered = pwrup_ack_q;

  // Sleep hold only once WIC enable has been up for a cycle
  a_hold_needs_wic : assert property (
    @(posedge MASTER_CLK) disable iff (!por_n)
    !sleepholdreqn |-> (pmu_wic_en_req && $past(pmu_wic_en_req))
  );

endmodule

// ==== clken_gen.sv ====
//--------------------------------------------------------------------
// Peripheral clock-enable generator
// One-cycle enable pulses for the timer, UART and watchdog, held
// off during system reset and deep sleep
//--------------------------------------------------------------------
`timescale 1ns/1ns

module clken_gen (
  input  logic                MASTER_CLK,
  input  logic                por_n,
  platform_status_if.consumer status,
  output logic                timer_clken,
  output logic                uart_clken,
  output logic                wdog_clken
);
  import platform_cfg_pkg::*;

  logic [2:0]       run;
  logic [2:0]       hit;
  logic [CNT_W-1:0] last [3];

  // Terminal counts, index 0 timer, 1 UART, 2 watchdog
  assign last[0] = CNT_W'(TIMER_DIV - 1);
  assign last[1] = CNT_W'(UART_DIV - 1);
  assign last[2] = CNT_W'(WDOG_DIV - 1);

  assign run[0] = status.sys_rst_n & ~status.asleep;
  assign run[1] = run[0];
  // Watchdog also stops while a debugger is attached
  assign run[2] = run[0] & ~status.dbg_powered;

  for (genvar g = 0; g < 3; g++) begin : g_prescale
    logic [CNT_W-1:0] cnt_q;

    assign hit[g] = run[g] && (cnt_q == last[g]);

    // Counter restarts from zero whenever gating ends
    always_ff @(posedge MASTER_CLK or negedge por_n) begin
      if (!por_n) begin
        cnt_q <= '0;
      end else if (!run[g] || hit[g]) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign timer_clken = hit[0];
  assign uart_clken  = hit[1];
  assign wdog_clken  = hit[2];

endmodule

// ==== platform_ctrl.sv ====
//--------------------------------------------------------------------
// Platform controller top level
// Power-on reset release, system and debug reset, deep-sleep
// handshake and peripheral clock enables for a small SoC
//--------------------------------------------------------------------
`timescale 1ns/1ns

module platform_ctrl (
  input  logic       MASTER_CLK,
  input  logic       PORESETn,
  input  logic       sysresetreq,
  input  logic       wdog_reset_req,
  input  logic       lockup,
  input  logic       dbgrstreq,
  input  logic       dbgpwrupreq,
  input  logic       dbgsyspwrupreq,
  input  logic       sleep,
  input  logic       sleepdeep,
  input  logic       pmu_wic_en_ack,
  input  logic       sleepholdackn,
  input  logic       pmu_wakeup,
  output logic       cpu_poreset_n,
  output logic       cpu_sysreset_n,
  output logic       dap_reset_n,
  output logic       dbgrstack,
  output logic       dbgpwrupack,
  output logic       dbgsyspwrupack,
  output logic       pmu_wic_en_req,
  output logic       sleepholdreqn,
  output logic       timer_clken,
  output logic       uart_clken,
  output logic       wdog_clken,
  output logic       asleep,
  output logic [1:0] reset_cause
);
  import platform_cfg_pkg::*;

  logic sysresetreq_s;
  logic wdog_req_s;
  logic lockup_s;
  logic dbgrstreq_s;
  logic dbgpwrupreq_s;
  logic dbgsyspwrupreq_s;

  platform_status_if status ();

  //------------------------------------------------------------------
  // Synchronizers
  //------------------------------------------------------------------

  // Power-on reset release
  reset_sync i_por_sync (
    .MASTER_CLK (MASTER_CLK),
    .rst_n      (PORESETn),
    .d          (1'b1),
    .q          (cpu_poreset_n)
  );

  reset_sync i_sysreq_sync (
    .MASTER_CLK (MASTER_CLK),
    .rst_n      (cpu_poreset_n),
    .d          (sysresetreq),
    .q          (sysresetreq_s)
  );

  reset_sync i_wdogreq_sync (
    .MASTER_CLK (MASTER_CLK),
    .rst_n      (cpu_poreset_n),
    .d          (wdog_reset_req),
    .q          (wdog_req_s)
  );

  reset_sync i_lockup_sync (
    .MASTER_CLK (MASTER_CLK),
    .rst_n      (cpu_poreset_n),
    .d          (lockup),
    .q          (lockup_s)
  );

  // Debug requests get their last stage in the receiving block
  reset_sync #(.STAGES(SYNC_STAGES - 1)) i_dbgrst_sync (
    .MASTER_CLK (MASTER_CLK),
    .rst_n      (cpu_poreset_n),
    .d          (dbgrstreq),
    .q          (dbgrstreq_s)
  );

  reset_sync #(.STAGES(SYNC_STAGES - 1)) i_dbgpwr_sync (
    .MASTER_CLK (MASTER_CLK),
    .rst_n      (cpu_poreset_n),
    .d          (dbgpwrupreq),
    .q          (dbgpwrupreq_s)
  );

  reset_sync #(.STAGES(SYNC_STAGES - 1)) i_dbgsyspwr_sync (
    .MASTER_CLK (MASTER_CLK),
    .rst_n      (cpu_poreset_n),
    .d          (dbgsyspwrupreq),
    .q          (dbgsyspwrupreq_s)
  );

  //------------------------------------------------------------------
  // Control blocks
  //------------------------------------------------------------------

  sys_reset_ctrl i_sys_reset_ctrl (
    .MASTER_CLK     (MASTER_CLK),
    .por_n          (cpu_poreset_n),
    .sysresetreq_s  (sysresetreq_s),
    .wdog_req_s     (wdog_req_s),
    .lockup_s       (lockup_s),
    .dbgrstreq_s    (dbgrstreq_s),
    .dap_reset_n    (dap_reset_n),
    .cpu_sysreset_n (cpu_sysreset_n),
    .status         (status.rst_src)
  );

  lowpower_ctrl i_lowpower_ctrl (
    .MASTER_CLK       (MASTER_CLK),
    .por_n            (cpu_poreset_n),
    .sleep            (sleep),
    .sleepdeep        (sleepdeep),
    .pmu_wic_en_ack   (pmu_wic_en_ack),
    .sleepholdackn    (sleepholdackn),
    .pmu_wakeup       (pmu_wakeup),
    .dbgpwrupreq_s    (dbgpwrupreq_s),
    .dbgsyspwrupreq_s (dbgsyspwrupreq_s),
    .pmu_wic_en_req   (pmu_wic_en_req),
    .sleepholdreqn    (sleepholdreqn),
    .dbgpwrupack      (dbgpwrupack),
    .dbgsyspwrupack   (dbgsyspwrupack),
    .status           (status.lp_src)
  );

  clken_gen i_clken_gen (
    .MASTER_CLK  (MASTER_CLK),
    .por_n       (cpu_poreset_n),
    .status      (status.consumer),
    .timer_clken (timer_clken),
    .uart_clken  (uart_clken),
    .wdog_clken  (wdog_clken)
  );

  // Debug reset ack mirrors the reset itself
  assign dbgrstack   = ~dap_reset_n;
  assign asleep      = status.asleep;
  assign reset_cause = status.reset_cause;

endmodule

// ==== tb_platform_ctrl.sv ====
//--------------------------------------------------------------------
// Platform controller testbench
// Replays the step trace against the DUT, checks output levels and
// clock-enable pulse counts, and reports each test
//--------------------------------------------------------------------
`timescale 1ns/1ns

module tb_platform_ctrl;

  logic       MASTER_CLK = 1'b0;
  logic       PORESETn;
  logic       sysresetreq;
  logic       wdog_reset_req;
  logic       lockup;
  logic       dbgrstreq;
  logic       dbgpwrupreq;
  logic       dbgsyspwrupreq;
  logic       sleep;
  logic       sleepdeep;
  logic       pmu_wic_en_ack;
  logic       sleepholdackn;
  logic       pmu_wakeup;
  logic       cpu_poreset_n;
  logic       cpu_sysreset_n;
  logic       dap_reset_n;
  logic       dbgrstack;
  logic       dbgpwrupack;
  logic       dbgsyspwrupack;
  logic       pmu_wic_en_req;
  logic       sleepholdreqn;
  logic       timer_clken;
  logic       uart_clken;
  logic       wdog_clken;
  logic       asleep;
  logic [1:0] reset_cause;

  // Fields of the current trace line
  string       line;
  int          line_no;
  int          step_test;
  int          step_op;
  logic [10:0] step_in;
  int          step_cycles;
  logic [8:0]  step_lvl;
  int          step_cause;
  int          exp_timer;
  int          exp_uart;
  int          exp_wdog;
  int          step_tol;

  // Bookkeeping
  int          fd;
  int          n_fields;
  int          cur_test;
  int          test_errors;
  int          total_errors;
  int          tests_run;
  int          tests_failed;
  int          setup_errors;

  always #5 MASTER_CLK = ~MASTER_CLK;

  platform_ctrl i_dut (.*);

  // Level outputs in trace column order
  function automatic logic [8:0] output_levels();
    return {cpu_poreset_n, cpu_sysreset_n, dap_reset_n, dbgrstack, dbgpwrupack,
            dbgsyspwrupack, pmu_wic_en_req, sleepholdreqn, asleep};
  endfunction

  // Negative expected count means unchecked
  task automatic check_count(input string name, input int got, input int exp);
    if (exp >= 0) begin
      assert ((got >= exp - step_tol) && (got <= exp + step_tol)) else begin
        $display("FAIL %0t: test %0d line %0d, %0s pulses %0d, expected %0d +/- %0d",
                 $time, step_test, line_no, name, got, exp, step_tol);
        test_errors++;
      end
    end
  endtask

  //------------------------------------------------------------------
  // One trace step, entered and left on a rising edge
  //------------------------------------------------------------------
  task automatic run_step();
    int         timer_n;
    int         uart_n;
    int         wdog_n;
    int         k;
    logic       matched;
    logic [8:0] got_lvl;
    logic [1:0] got_cause;
    timer_n = 0;
    uart_n  = 0;
    wdog_n  = 0;
    k       = 0;
    matched = 1'b0;
    {sysresetreq, wdog_reset_req, lockup, dbgrstreq, dbgpwrupreq, dbgsyspwrupreq,
     sleep, sleepdeep, pmu_wic_en_ack, sleepholdackn, pmu_wakeup} <= step_in;
    // Sample mid-cycle, op 1 stops at the first matching cycle
    while ((k < step_cycles) && !matched) begin
      @(negedge MASTER_CLK);
      if (timer_clken) timer_n++;
      if (uart_clken) uart_n++;
      if (wdog_clken) wdog_n++;
      got_lvl   = output_levels();
      got_cause = reset_cause;
      k++;
      if (step_op == 1) begin
        matched = (got_lvl === step_lvl) && (got_cause === 2'(step_cause));
      end
      @(posedge MASTER_CLK);
    end
    if (step_op == 1) begin
      assert (matched) else begin
        $display("Timeout in test %0d line %0d: outputs did not reach %b cause %0d in %0d cycles",
                 step_test, line_no, step_lvl, step_cause, step_cycles);
        test_errors++;
      end
    end else begin
      assert (got_lvl === step_lvl) else begin
        $display("FAIL %0t: test %0d line %0d, levels %b, expected %b",
                 $time, step_test, line_no, got_lvl, step_lvl);
        test_errors++;
      end
      assert (got_cause === 2'(step_cause)) else begin
        $display("FAIL %0t: test %0d line %0d, reset_cause %0d, expected %0d",
                 $time, step_test, line_no, got_cause, step_cause);
        test_errors++;
      end
    end
    check_count("timer", timer_n, exp_timer);
    check_count("uart", uart_n, exp_uart);
    check_count("wdog", wdog_n, exp_wdog);
  endtask

  task automatic end_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("Test %0d ok", cur_test);
    end else begin
      tests_failed++;
      $display("Test %0d failed with %0d errors", cur_test, test_errors);
    end
  endtask

  //------------------------------------------------------------------
  // Main sequence
  //------------------------------------------------------------------
  initial begin
    PORESETn       <= 1'b0;
    sysresetreq    <= 1'b0;
    wdog_reset_req <= 1'b0;
    lockup         <= 1'b0;
    dbgrstreq      <= 1'b0;
    dbgpwrupreq    <= 1'b0;
    dbgsyspwrupreq <= 1'b0;
    sleep          <= 1'b0;
    sleepdeep      <= 1'b0;
    pmu_wic_en_ack <= 1'b0;
    sleepholdackn  <= 1'b1;
    pmu_wakeup     <= 1'b0;
    repeat (3) @(posedge MASTER_CLK);
    PORESETn <= 1'b1;
    fd = $fopen("platform_trace.txt", "r");
    if (fd == 0) begin
      $display("Cannot open platform_trace.txt, no tests were run");
      setup_errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        line_no++;
        n_fields = $sscanf(line, "%d %d %b %d %b %d %d %d %d %d", step_test, step_op,
                           step_in, step_cycles, step_lvl, step_cause, exp_timer,
                           exp_uart, exp_wdog, step_tol);
        if (n_fields == 10) begin
          if (step_test != cur_test) begin
            if (cur_test != 0) end_test();
            cur_test    = step_test;
            test_errors = 0;
          end
          run_step();
        end else if (n_fields > 0) begin
          $display("Trace line %0d has %0d fields instead of 10", line_no, n_fields);
          setup_errors++;
        end
      end
      $fclose(fd);
      if (cur_test != 0) end_test();
    end
    $display("Tests run %0d, tests failed %0d, failed checks %0d, trace errors %0d",
             tests_run, tests_failed, total_errors, setup_errors);
    if ((tests_failed == 0) && (setup_errors == 0) && (tests_run > 0)) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== platform_trace.txt ====
# test op inputs cycles levels cause timer uart wdog tol  (op 0 run and check last cycle, op 1 wait)
# inputs sysrst,wdog,lockup,dbgrst,dbgpwr,dbgsyspwr,sleep,deep,wicack,holdackn,wakeup; count -1 unchecked
# levels poreset_n,sysreset_n,dap_reset_n,dbgrstack,pwrack,syspwrack,wic_req,holdreqn,asleep
1 0 00000000010 2  000100010 0  0  0  0 0
1 0 00000000010 1  100100010 0  0  0  0 0
1 0 00000000010 1  111000010 0  0  0  0 0
2 0 10000000010 3  111000010 0 -1 -1 -1 0
2 0 00000000010 1  101000010 1  0  0  0 0
2 0 00000000010 10 101000010 1  0  0  0 0
2 0 00000000010 1  111000010 1  0  0  0 0
3 1 01100000010 10 101000010 2 -1 -1 -1 0
3 1 00000000010 20 111000010 2 -1 -1 -1 0
3 1 00100000010 10 101000010 3 -1 -1 -1 0
3 1 00000000010 20 111000010 3 -1 -1 -1 0
4 0 00010000010 2  111000010 3 -1 -1 -1 0
4 0 00010000010 1  110100010 3 -1 -1 -1 0
4 0 00000000010 2  110100010 3 -1 -1 -1 0
4 0 00000000010 1  111000010 3 -1 -1 -1 0
4 0 00001100010 2  111000010 3 -1 -1 -1 0
4 0 00001100010 1  111011010 3 -1 -1 -1 0
4 0 00001100010 48 111011010 3 -1 -1  0 0
4 0 00000000010 3  111000010 3 -1 -1 -1 0
5 1 00000011010 10 111000110 3 -1 -1 -1 0
5 1 00000011110 10 111000100 3 -1 -1 -1 0
5 1 00000011100 10 111000101 3 -1 -1 -1 0
5 0 00000011100 32 111000101 3  0  0  0 0
5 1 00000000011 10 111000010 3 -1 -1 -1 0
6 0 00000000010 64 111000010 3 16  8  4 1

// ==== build.f ====
platform_cfg_pkg.sv
platform_types_pkg.sv
platform_status_if.sv
reset_sync.sv
sys_reset_ctrl.sv
lowpower_ctrl.sv
clken_gen.sv
platform_ctrl.sv
tb_platform_ctrl.sv
